/* logic/bus_event_reporter.sv */
/*
  Bus event reporter
  Turns detection strobes into coded, registered event strobes and
  tracks whether the bus is busy
*/

`timescale 1ns/1ps

module bus_event_reporter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    start_det_i,
  input  logic                    stop_det_i,
  input  logic                    hdr_exit_det_i,
  output logic                    event_valid_o,
  output bus_mon_pkg::bus_event_e event_code_o,
  output logic                    bus_busy_o
);

  bus_mon_pkg::bus_state_e state_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= bus_mon_pkg::ST_IDLE;
      event_valid_o <= 1'b0;
      event_code_o  <= bus_mon_pkg::EV_NONE;
    end else begin
      event_valid_o <= 1'b0;  // Strobe by default
      event_code_o  <= bus_mon_pkg::EV_NONE;
      if (!enable_i) begin
        state_q <= bus_mon_pkg::ST_IDLE;
      end else if (stop_det_i) begin
        event_valid_o <= 1'b1;
        event_code_o  <= hdr_exit_det_i ? bus_mon_pkg::EV_HDR_EXIT : bus_mon_pkg::EV_STOP;
        state_q       <= bus_mon_pkg::ST_IDLE;
      end else if (start_det_i) begin
        event_valid_o <= 1'b1;
        // A START on a busy bus is a repeated START
        event_code_o  <= (state_q == bus_mon_pkg::ST_IDLE) ? bus_mon_pkg::EV_START
                                                           : bus_mon_pkg::EV_RSTART;
        state_q       <= bus_mon_pkg::ST_BUSY;
      end
    end
  end

  assign bus_busy_o = (state_q == bus_mon_pkg::ST_BUSY);

endmodule

/* logic/bus_line_sync.sv */
/*
  Bus line synchronizer
  Two flop stages per line; both lines reset to the idle-high level
*/

`timescale 1ns/1ps

module bus_line_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o
);

  logic [1:0] scl_ff;
  logic [1:0] sda_ff;

  // Idle high at reset, so no false START is seen as reset releases
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_ff <= 2'b11;
      sda_ff <= 2'b11;
    end else begin
      scl_ff <= {scl_ff[0], scl_i};  // Stage 0 may go metastable
      sda_ff <= {sda_ff[0], sda_i};
    end
  end

  assign scl_o = scl_ff[1];
  assign sda_o = sda_ff[1];

endmodule

/* logic/bus_mon_pkg.sv */
/*
  Bus monitor package
  Shared widths, HDR exit edge count, event codes and reporter states
*/

package bus_mon_pkg;

  localparam int unsigned TIMER_W   = 20;  // t_r, t_f and t_hd_dat inputs
  localparam int unsigned DET_CNT_W = 14;  // START/STOP hold counter

  // SDA falls needed while SCL is low before the STOP that ends HDR mode
  localparam int unsigned HDR_EXIT_EDGES = 4;

  // Codes carried on event_code_o
  typedef enum logic [2:0] {
    EV_NONE     = 3'd0,
    EV_START    = 3'd1,
    EV_RSTART   = 3'd2,
    EV_STOP     = 3'd3,
    EV_HDR_EXIT = 3'd4
  } bus_event_e;

  // Reporter view of the bus
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } bus_state_e;

endpackage

/* logic/bus_monitor.sv */
/*
  Bus condition monitor
  Qualifies SCL/SDA edges against rise and fall times, then detects START,
  STOP and the HDR exit pattern, each held for t_hd_dat cycles
*/

`timescale 1ns/1ps

module bus_monitor (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            enable_i,
  input  logic                            scl_i,          // Synchronized SCL
  input  logic                            sda_i,          // Synchronized SDA
  input  logic                            hdr_mode_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] t_hd_dat_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] t_r_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] t_f_i,
  output logic                            start_det_o,
  output logic                            stop_det_o,
  output logic                            hdr_exit_det_o
);

  logic scl_q;
  logic sda_q;

  // Raw edges of the synchronized lines
  logic scl_fall_raw;
  logic scl_rise_raw;
  logic sda_fall_raw;
  logic sda_rise_raw;

  // Qualified edges and stable levels
  logic scl_negedge;
  logic scl_posedge;
  logic sda_negedge;
  logic sda_posedge;
  logic sda_stable_high;
  logic scl_stable_high;
  logic scl_stable_low;
  logic sda_low_q;

  logic                              start_trig;
  logic                              stop_trig;
  logic                              start_pend_q;
  logic                              stop_pend_q;
  logic                              hold_done;
  logic                              start_det;
  logic                              stop_det;
  logic [bus_mon_pkg::DET_CNT_W-1:0] det_cnt_q;

  logic                                              hdr_arm;
  logic                                              hdr_pend_q;
  logic [$clog2(bus_mon_pkg::HDR_EXIT_EDGES+1)-1:0] hdr_fall_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
    end
  end

  assign scl_fall_raw = scl_q & !scl_i;
  assign scl_rise_raw = !scl_q & scl_i;
  assign sda_fall_raw = sda_q & !sda_i;
  assign sda_rise_raw = !sda_q & sda_i;

  edge_detector #(.DETECT_NEGEDGE(1'b1)) u_scl_fall (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .trigger_i     (scl_fall_raw),
    .line_i        (scl_i),
    .delay_count_i (t_f_i),
    .detect_o      (scl_negedge)
  );

  edge_detector #(.DETECT_NEGEDGE(1'b0)) u_scl_rise (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .trigger_i     (scl_rise_raw),
    .line_i        (scl_i),
    .delay_count_i (t_r_i),
    .detect_o      (scl_posedge)
  );

  edge_detector #(.DETECT_NEGEDGE(1'b1)) u_sda_fall (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .trigger_i     (sda_fall_raw),
    .line_i        (sda_i),
    .delay_count_i (t_f_i),
    .detect_o      (sda_negedge)
  );

  edge_detector #(.DETECT_NEGEDGE(1'b0)) u_sda_rise (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .trigger_i     (sda_rise_raw),
    .line_i        (sda_i),
    .delay_count_i (t_r_i),
    .detect_o      (sda_posedge)
  );

  stable_high_detector u_sda_high (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .line_i        (sda_i),
    .delay_count_i (t_r_i),
    .stable_o      (sda_stable_high)
  );

  stable_high_detector u_scl_high (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .line_i        (scl_i),
    .delay_count_i (t_r_i),
    .stable_o      (scl_stable_high)
  );

  // Stable low is stable high of the inverted line
  stable_high_detector u_scl_low (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .line_i        (!scl_i),
    .delay_count_i (t_f_i),
    .stable_o      (scl_stable_low)
  );

  // SDA confirmed low by a qualified fall, so only a matching rise is a STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_low_q <= 1'b0;
    end else if (sda_negedge) begin
      sda_low_q <= 1'b1;
    end else if (sda_posedge) begin
      sda_low_q <= 1'b0;
    end
  end

  // SDA moves while SCL is high; a joint edge with SCL is data, not a condition
  assign start_trig = enable_i & scl_stable_high & sda_negedge & !scl_negedge;
  assign stop_trig  = enable_i & scl_stable_high & sda_low_q & sda_posedge & !scl_posedge;

  // One hold counter serves both START and STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      det_cnt_q <= '0;
    end else if (start_trig || stop_trig) begin
      det_cnt_q <= {{(bus_mon_pkg::DET_CNT_W-1){1'b0}}, 1'b1};
    end else if (start_pend_q || stop_pend_q) begin
      det_cnt_q <= det_cnt_q + 1'b1;
    end
  end

  assign hold_done = (det_cnt_q >= t_hd_dat_i[bus_mon_pkg::DET_CNT_W-1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pend_q <= 1'b0;
      stop_pend_q  <= 1'b0;
    end else begin
      if (start_trig) begin
        start_pend_q <= 1'b1;
      end else if (!enable_i || !scl_i || start_det || stop_trig) begin
        start_pend_q <= 1'b0;  // SCL fell or a STOP took over
      end
      if (stop_trig) begin
        stop_pend_q <= 1'b1;
      end else if (!enable_i || !scl_i || stop_det || start_trig) begin
        stop_pend_q <= 1'b0;
      end
    end
  end

  assign start_det = enable_i & start_pend_q & hold_done;
  assign stop_det  = enable_i & stop_pend_q & hold_done;

  // HDR exit: armed by SCL low with SDA high, then counts SDA falls
  assign hdr_arm = hdr_mode_i & scl_stable_low & sda_stable_high;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_pend_q     <= 1'b0;
      hdr_fall_cnt_q <= '0;
    end else if (!enable_i || stop_det) begin
      hdr_pend_q     <= 1'b0;
      hdr_fall_cnt_q <= '0;
    end else begin
      if (hdr_arm) begin
        hdr_pend_q <= 1'b1;
      end
      if (hdr_pend_q && sda_negedge && !scl_i &&
          hdr_fall_cnt_q != bus_mon_pkg::HDR_EXIT_EDGES) begin
        hdr_fall_cnt_q <= hdr_fall_cnt_q + 1'b1;
      end
    end
  end

  assign start_det_o    = start_det;
  assign stop_det_o     = stop_det;
  assign hdr_exit_det_o = stop_det & (hdr_fall_cnt_q == bus_mon_pkg::HDR_EXIT_EDGES);

endmodule

/* logic/bus_monitor_top.sv */
/*
  Bus monitor subsystem
  Synchronizer, condition monitor and event reporter
*/

`timescale 1ns/1ps

module bus_monitor_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            enable_i,
  input  logic                            scl_i,         // Raw, asynchronous
  input  logic                            sda_i,         // Raw, asynchronous
  input  logic [bus_mon_pkg::TIMER_W-1:0] t_r_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] t_f_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] t_hd_dat_i,
  input  logic                            hdr_mode_i,
  output logic                            event_valid_o,
  output bus_mon_pkg::bus_event_e         event_code_o,
  output logic                            bus_busy_o
);

  logic scl_sync;
  logic sda_sync;
  logic start_det;
  logic stop_det;
  logic hdr_exit_det;

  bus_line_sync u_sync (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .scl_o  (scl_sync),
    .sda_o  (sda_sync)
  );

  bus_monitor u_monitor (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .scl_i          (scl_sync),
    .sda_i          (sda_sync),
    .hdr_mode_i     (hdr_mode_i),
    .t_hd_dat_i     (t_hd_dat_i),
    .t_r_i          (t_r_i),
    .t_f_i          (t_f_i),
    .start_det_o    (start_det),
    .stop_det_o     (stop_det),
    .hdr_exit_det_o (hdr_exit_det)
  );

  bus_event_reporter u_reporter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .start_det_i    (start_det),
    .stop_det_i     (stop_det),
    .hdr_exit_det_i (hdr_exit_det),
    .event_valid_o  (event_valid_o),
    .event_code_o   (event_code_o),
    .bus_busy_o     (bus_busy_o)
  );

endmodule

/* logic/edge_detector.sv */
/*
  Edge qualifier
  Confirms a rising or falling edge once the line has kept its new level
  for delay_count_i cycles after the trigger
*/

`timescale 1ns/1ps

module edge_detector #(
  parameter bit DETECT_NEGEDGE = 1'b0  // 1 confirms falling edges
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            trigger_i,
  input  logic                            line_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] delay_count_i,
  output logic                            detect_o
);

  logic                            active_q;
  logic [bus_mon_pkg::TIMER_W-1:0] count_q;
  logic                            line_ok;
  logic                            zero_delay;

  assign line_ok    = DETECT_NEGEDGE ? !line_i : line_i;  // Line at the expected level
  assign zero_delay = (delay_count_i == '0);

  // Zero delay confirms in the trigger cycle itself
  assign detect_o = line_ok & ((trigger_i & zero_delay) |
                               (active_q & (count_q >= delay_count_i)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      count_q  <= '0;
    end else if (trigger_i) begin
      active_q <= line_ok & !zero_delay;
      count_q  <= {{(bus_mon_pkg::TIMER_W-1){1'b0}}, 1'b1};
    end else if (active_q) begin
      if (!line_ok || detect_o) begin
        active_q <= 1'b0;  // Glitch or done
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

/* logic/stable_high_detector.sv */
/*
  Stable-high detector
  Counts consecutive high cycles and flags the line once it has been high
  for delay_count_i cycles
*/

`timescale 1ns/1ps

module stable_high_detector (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            line_i,
  input  logic [bus_mon_pkg::TIMER_W-1:0] delay_count_i,
  output logic                            stable_o
);

  logic [bus_mon_pkg::TIMER_W-1:0] high_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      high_cnt_q <= '0;
    end else if (!line_i) begin
      high_cnt_q <= '0;
    end else if (high_cnt_q != '1) begin  // Saturate
      high_cnt_q <= high_cnt_q + 1'b1;
    end
  end

  // Drops one cycle after the line goes low
  assign stable_o = (high_cnt_q >= delay_count_i);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the bus monitor testbench with Verilator, run it, look for the pass line

verilator --binary --timing --assert --top-module tb_bus_monitor -f src.f -Mdir obj_dir &&
  ./obj_dir/Vtb_bus_monitor +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "Simulation finished: PASS" &&
  echo "run_sim: simulation passed" ||
  { echo "run_sim: simulation failed"; exit 1; }

/* src.f */
logic/bus_mon_pkg.sv
logic/bus_line_sync.sv
logic/edge_detector.sv
logic/stable_high_detector.sv
logic/bus_monitor.sv
logic/bus_event_reporter.sv
logic/bus_monitor_top.sv
test/tb_bus_monitor_assert.sv
test/tb_bus_monitor.sv

/* test/tb_bus_monitor.sv */
/*
  Bus monitor testbench
  Random bus phases from a fixed seed, checked against a phase-level model
*/

`timescale 1ns/1ps

module tb_bus_monitor;

  logic                            clk;
  logic                            rst_n;
  logic                            enable;
  logic                            scl;
  logic                            sda;
  logic                            hdr_mode;
  logic [bus_mon_pkg::TIMER_W-1:0] t_r_w;
  logic [bus_mon_pkg::TIMER_W-1:0] t_f_w;
  logic [bus_mon_pkg::TIMER_W-1:0] t_hd_w;
  logic                            event_valid;
  bus_mon_pkg::bus_event_e         event_code;
  logic                            bus_busy;

  integer                  seed;
  int                      t_r;
  int                      t_f;
  int                      t_hd;
  int                      phase_len;   // Cycles per bus phase
  bit                      mdl_busy;    // Model view of the bus
  string                   cur_test;
  int                      chk_errs;    // Owned by the stimulus process
  int                      mon_errs;    // Owned by the event monitor
  int                      rd_idx;
  int                      errs_at_start;
  int                      tests_failed;
  int unsigned             assert_fails;
  bus_mon_pkg::bus_event_e exp_q[$];
  bus_mon_pkg::bus_event_e exp_code;

  assign t_r_w  = t_r[bus_mon_pkg::TIMER_W-1:0];
  assign t_f_w  = t_f[bus_mon_pkg::TIMER_W-1:0];
  assign t_hd_w = t_hd[bus_mon_pkg::TIMER_W-1:0];

  bus_monitor_top dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .enable_i      (enable),
    .scl_i         (scl),
    .sda_i         (sda),
    .t_r_i         (t_r_w),
    .t_f_i         (t_f_w),
    .t_hd_dat_i    (t_hd_w),
    .hdr_mode_i    (hdr_mode),
    .event_valid_o (event_valid),
    .event_code_o  (event_code),
    .bus_busy_o    (bus_busy)
  );

  always #20 clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  function automatic void model_start();
    if (enable) begin
      exp_q.push_back(mdl_busy ? bus_mon_pkg::EV_RSTART : bus_mon_pkg::EV_START);
      mdl_busy = 1'b1;
    end
  endfunction

  // Enough SDA falls in HDR mode turn the STOP into an HDR exit
  function automatic void model_stop(input int sda_falls);
    if (enable) begin
      if (hdr_mode && sda_falls >= bus_mon_pkg::HDR_EXIT_EDGES) begin
        exp_q.push_back(bus_mon_pkg::EV_HDR_EXIT);
      end else begin
        exp_q.push_back(bus_mon_pkg::EV_STOP);
      end
      mdl_busy = 1'b0;
    end
  endfunction

  task automatic step(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic phase(input logic s, input logic d);
    scl = s;
    sda = d;
    step(phase_len);
  endtask

  task automatic pick_timing(input int f_lo, input int hd_lo);
    int longest;
    t_r  = rand_range(1, 8);
    t_f  = rand_range(f_lo, 8);
    t_hd = rand_range(hd_lo, 8);  // Well inside the DET_CNT_W hold counter
    longest = (t_r > t_f) ? t_r : t_f;
    longest = (t_hd > longest) ? t_hd : longest;
    phase_len = 3 * longest + 10;
  endtask

  task automatic send_start();  // From idle high, leaves both lines low
    model_start();
    phase(1'b1, 1'b0);
    phase(1'b0, 1'b0);
  endtask

  task automatic send_stop(input int sda_falls);  // From SCL low, ends idle high
    phase(1'b0, 1'b0);
    phase(1'b1, 1'b0);
    model_stop(sda_falls);
    phase(1'b1, 1'b1);
  endtask

  task automatic data_bit(input int b);
    phase(1'b0, b != 0);
    phase(1'b1, b != 0);
    phase(1'b0, b != 0);
  endtask

  // SCL held low, SDA falls n times and stays low after the last one
  task automatic hdr_pattern(input int n);
    phase(1'b0, 1'b1);
    for (int i = 1; i <= n; i++) begin
      phase(1'b0, 1'b0);
      if (i < n) begin
        phase(1'b0, 1'b1);
      end
    end
    send_stop(n);
  endtask

  task automatic check_busy();
    if (bus_busy !== mdl_busy) begin
      $display("FAILED %s: bus_busy expected %0b, actual %0b", cur_test, mdl_busy, bus_busy);
      chk_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    errs_at_start = chk_errs + mon_errs;
  endtask

  task automatic end_test();
    int waited;
    int test_errs;
    waited = 0;
    while (rd_idx < exp_q.size() && waited < 4 * phase_len) begin
      @(negedge clk);
      waited++;
    end
    if (rd_idx < exp_q.size()) begin
      $display("test %s: %0d expected events never appeared", cur_test, exp_q.size() - rd_idx);
      chk_errs++;
    end
    test_errs = chk_errs + mon_errs - errs_at_start;
    if (test_errs == 0) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  // Outputs are registered on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n && event_valid) begin
      if (rd_idx >= exp_q.size()) begin
        $display("test %s: unexpected event %s", cur_test, event_code.name());
        mon_errs++;
      end else begin
        exp_code = exp_q[rd_idx];
        if (event_code !== exp_code) begin
          $display("FAILED %s: expected %s, actual %s", cur_test, exp_code.name(),
                   event_code.name());
          mon_errs++;
        end
        rd_idx++;
      end
    end
  end

  initial begin
    int lag;
    clk          = 1'b0;
    rst_n        = 1'b0;
    enable       = 1'b1;
    scl          = 1'b1;
    sda          = 1'b1;
    hdr_mode     = 1'b0;
    seed         = 81058;
    t_r          = 1;
    t_f          = 1;
    t_hd         = 1;
    phase_len    = 34;
    mdl_busy     = 1'b0;
    chk_errs     = 0;
    mon_errs     = 0;
    rd_idx       = 0;
    tests_failed = 0;
    step(4);
    rst_n = 1'b1;

    begin_test("idle");
    pick_timing(1, 1);
    step(2 * phase_len);
    check_busy();
    end_test();

    begin_test("start_stop");
    pick_timing(1, 1);
    send_start();
    check_busy();
    send_stop(0);
    check_busy();
    end_test();

    begin_test("rstart");
    pick_timing(1, 1);
    send_start();
    repeat (rand_range(1, 4)) data_bit(rand_range(0, 1));
    phase(1'b0, 1'b1);
    phase(1'b1, 1'b1);
    send_start();
    data_bit(rand_range(0, 1));
    send_stop(0);
    end_test();

    begin_test("glitch");
    pick_timing(2, 3);
    // A low pulse shorter than t_f is no condition at all
    sda = 1'b0;
    step(rand_range(1, t_f - 1));
    sda = 1'b1;
    step(phase_len);
    check_busy();
    phase(1'b0, 1'b1);
    repeat (3) begin
      phase(1'b0, 1'b0);
      phase(1'b0, 1'b1);
    end
    phase(1'b1, 1'b1);
    lag = t_f + rand_range(1, t_hd - 1);  // SCL falls inside the hold time
    sda = 1'b0;
    step(lag);
    scl = 1'b0;
    step(phase_len);
    phase(1'b0, 1'b1);
    phase(1'b1, 1'b1);
    check_busy();
    end_test();

    begin_test("hdr_exit");
    pick_timing(1, 1);
    hdr_mode = 1'b1;
    hdr_pattern(bus_mon_pkg::HDR_EXIT_EDGES);
    hdr_pattern(bus_mon_pkg::HDR_EXIT_EDGES - 1);
    hdr_mode = 1'b0;
    end_test();

    begin_test("enable");
    pick_timing(1, 1);
    enable = 1'b0;
    send_start();
    data_bit(1);
    send_stop(0);
    enable = 1'b1;
    step(phase_len);
    send_start();
    check_busy();
    enable = 1'b0;
    mdl_busy = 1'b0;  // Reporter forced idle
    step(2);
    check_busy();
    send_stop(0);
    enable = 1'b1;
    step(phase_len);
    check_busy();
    end_test();

    assert_fails = dut0.u_reporter.u_assert.fail_count;
    $display("tests run 6, failed %0d, check errors %0d, assertion failures %0d",
             tests_failed, chk_errs + mon_errs, assert_fails);
    if (chk_errs + mon_errs == 0 && assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* test/tb_bus_monitor_assert.sv */
/*
  Reporter assertions
  Event strobes carry a code, last one cycle, and a STOP leaves the bus idle
*/

`timescale 1ns/1ps

module tb_bus_monitor_assert (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    event_valid_i,
  input bus_mon_pkg::bus_event_e event_code_i,
  input logic                    bus_busy_i
);

  int unsigned fail_count = 0;  // Read by the testbench at the end

  valid_has_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
    event_valid_i |-> (event_code_i != bus_mon_pkg::EV_NONE))
    else begin
      $error("event strobe carries EV_NONE");
      fail_count++;
    end

  valid_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    event_valid_i |=> !event_valid_i)
    else begin
      $error("event strobe held for two cycles");
      fail_count++;
    end

  // Reporter state and event update on the same edge
  stop_clears_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (event_valid_i && (event_code_i == bus_mon_pkg::EV_STOP ||
                       event_code_i == bus_mon_pkg::EV_HDR_EXIT))
    |-> !bus_busy_i)
    else begin
      $error("bus still busy after a STOP event");
      fail_count++;
    end

endmodule

bind bus_event_reporter tb_bus_monitor_assert u_assert (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .event_valid_i (event_valid_o),
  .event_code_i  (event_code_o),
  .bus_busy_i    (bus_busy_o)
);
